// File: include/sprite_macros.svh
`ifndef SPRITE_MACROS_SVH
`define SPRITE_MACROS_SVH

// ---------------------------------------------------------------------------
// sprite engine sizing
// ---------------------------------------------------------------------------

// number of sprite descriptors, scanned in index order every line
`define SPRITE_COUNT 16

// sprite index width, follows the descriptor count
`define SPRITE_IDX_W $clog2(`SPRITE_COUNT)

// ---------------------------------------------------------------------------
// display geometry
// ---------------------------------------------------------------------------

`define VIS_LINES 288   // visible lines per frame

// entries per line buffer half, one per visible column
`define LINE_PIXELS 360

`endif

// File: design/video_pkg.sv
`default_nettype none

package video_pkg;

	// -----------------------------------------------------------------------
	// line geometry
	// -----------------------------------------------------------------------

	typedef logic [8:0] vline_t;   // display line number
	typedef logic [8:0] xpos_t;    // pixel column, 0..359 on screen

	// output colour as sent to the video mixer
	typedef logic [5:0] color_t;

	// -----------------------------------------------------------------------
	// line buffer entry
	// -----------------------------------------------------------------------

	// opaque clear means nothing drawn here, mixer shows the layer below
	typedef struct packed
	{
		logic   opaque;   // sprite pixel present
		color_t color;
	} sl_word_t;          // 7 bits

endpackage

`default_nettype wire

// File: design/sprite_pkg.sv
`default_nettype none

package sprite_pkg;

	// word address into external sprite memory
	typedef logic [20:0] mem_addr_t;

	// colour resolution of a sprite
	typedef enum logic [1:0]
	{
		off         = 2'd0,   // sprite disabled
		four_col    = 2'd1,   // 2 bits per pixel, 8 pixels per word
		sixteen_col = 2'd2,   // 4 bits per pixel, 4 pixels per word
		true_col    = 2'd3    // one byte per pixel, 2 pixels per word
	} cres_e;

	// -----------------------------------------------------------------------
	// sprite descriptor, eight host bytes, byte n at bits [8n+7:8n]
	// -----------------------------------------------------------------------
	typedef struct packed
	{
		logic [13:0]       base_addr;     // bytes 7..6, top bits of mem_addr_t
		logic              flip_y;
		logic              flip_x;
		logic [5:0]        pal_sel;       // byte 5 [7:2]
		cres_e             cres;          // byte 5 [1:0]
		logic              rsv_h;
		logic [6:0]        height_lines;  // byte 4, units of 4 lines
		logic              rsv_w;
		logic [6:0]        width_words;   // byte 3, 16-bit words per row
		logic [5:0]        rsv_p;
		video_pkg::vline_t y_pos;         // bytes 2..1
		video_pkg::xpos_t  x_pos;         // bytes 1..0
	} sprite_desc_t;

	// sequencer states
	typedef enum logic [2:0]
	{
		halt,        // idle, line done or nothing to draw
		spr_check,   // cres and visibility test of current sprite
		spr_setup,   // load row address and start column
		word_wait,   // request out, waiting for memory strobe
		pix_out,     // one pixel per cycle into back buffer
		spr_next     // step to next sprite
	} seq_state_e;

endpackage

`default_nettype wire

// File: design/sprite_attr_file.sv
`timescale 1ns/10ps
`default_nettype none

`include "sprite_macros.svh"

module sprite_attr_file
(
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       wr_en,
	input  logic [`SPRITE_IDX_W-1:0]   wr_sprite,
	input  logic [2:0]                 wr_byte,
	input  logic [7:0]                 wr_data,
	input  logic [`SPRITE_IDX_W-1:0]   rd_sprite,
	output sprite_pkg::sprite_desc_t   desc
);
	import sprite_pkg::*;

	sprite_desc_t regs [`SPRITE_COUNT];   // one descriptor per sprite

	// host byte writes
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < `SPRITE_COUNT; i++)
				regs[i] <= '0;   // cres comes up as off
		end
		else if (wr_en)
			regs[wr_sprite][{wr_byte, 3'b000} +: 8] <= wr_data;
	end

	// whole descriptor of the sprite being scanned
	assign desc = regs[rd_sprite];

endmodule

`default_nettype wire

// File: design/sprite_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "sprite_macros.svh"

module sprite_sequencer
(
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       spu_en,
	input  logic                       line_start,
	input  logic                       pre_vline,
	input  sprite_pkg::sprite_desc_t   desc,
	input  logic                       spu_strobe,
	input  sprite_pkg::mem_addr_t      row_addr,
	input  video_pkg::xpos_t           first_x,
	output logic [`SPRITE_IDX_W-1:0]   sprite_idx,
	output logic                       row_load,
	output video_pkg::vline_t          line,
	output logic                       spu_req,
	output sprite_pkg::mem_addr_t      spu_addr,
	output logic                       load_word,
	output logic [2:0]                 slot,
	output logic                       pix_wr,
	output video_pkg::xpos_t           wr_x,
	output sprite_pkg::seq_state_e     state,
	output logic                       back_sel
);
	import video_pkg::*;
	import sprite_pkg::*;

	vline_t     line_nxt;
	logic       line_vis;     // current render line inside the frame
	logic       render_go;
	logic [9:0] y_end;        // first line below the sprite
	logic       spr_hit;
	logic       last_spr;
	logic [2:0] last_slot;
	logic [6:0] word_cnt;     // words left in this row

	// -----------------------------------------------------------------------
	// line counter, advanced at line_start
	// -----------------------------------------------------------------------
	assign line_vis = (line != `VIS_LINES);

	always_comb
	begin
		if (pre_vline)
			line_nxt = '0;          // frame restart
		else if (line_vis)
			line_nxt = line + 9'd1;
		else
			line_nxt = line;        // parked in blanking
	end

	assign render_go = spu_en && (line_nxt != `VIS_LINES);

	// -----------------------------------------------------------------------
	// sprite tests, desc belongs to sprite_idx
	// -----------------------------------------------------------------------
	assign y_end = {1'b0, desc.y_pos} + {1'b0, desc.height_lines, 2'b00};

	assign spr_hit = (desc.cres != off) && (desc.width_words != 7'd0)
		&& (line >= desc.y_pos) && ({1'b0, line} < y_end);

	assign last_spr = (sprite_idx == (`SPRITE_COUNT - 1));

	// slot of the last pixel in a word
	always_comb
	begin
		case (desc.cres)
			four_col:    last_slot = 3'd7;
			sixteen_col: last_slot = 3'd3;
			true_col:    last_slot = 3'd1;
			default:     last_slot = 3'd0;
		endcase
	end

	assign row_load  = (state == spr_check) && spr_hit;   // row_addr latches this
	assign load_word = (state == word_wait) && spu_strobe;
	assign pix_wr    = (state == pix_out);

	// -----------------------------------------------------------------------
	// control FSM
	// -----------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			line       <= '0;
			back_sel   <= 1'b0;
			state      <= halt;
			sprite_idx <= '0;
			spu_req    <= 1'b0;
			spu_addr   <= '0;
			slot       <= '0;
			wr_x       <= '0;
			word_cnt   <= '0;
		end
		else if (line_start)
		begin
			// aborts any unfinished sprite
			line       <= line_nxt;
			if (pre_vline || line_vis)
				back_sel <= ~back_sel;   // swap halves
			sprite_idx <= '0;
			spu_req    <= 1'b0;
			state      <= render_go ? spr_check : halt;
		end
		else
		begin
			case (state)
				halt: ;

				spr_check:
				begin
					if (spr_hit)
						state <= spr_setup;
					else
						state <= spr_next;   // off or not on this line
				end

				spr_setup:
				begin
					spu_addr <= row_addr;         // registered last cycle
					wr_x     <= first_x;
					word_cnt <= desc.width_words;
					slot     <= '0;
					spu_req  <= 1'b1;
					state    <= word_wait;
				end

				word_wait:
				begin
					if (spu_strobe)
					begin
						spu_req  <= 1'b0;                  // drop after strobe
						spu_addr <= spu_addr + 21'd1;
						slot     <= '0;
						state    <= pix_out;
					end
				end

				pix_out:
				begin
					wr_x <= desc.flip_x ? wr_x - 9'd1 : wr_x + 9'd1;
					if (slot == last_slot)
					begin
						if (word_cnt == 7'd1)
							state <= spr_next;   // row complete
						else
						begin
							word_cnt <= word_cnt - 7'd1;
							spu_req  <= 1'b1;     // next word
							state    <= word_wait;
						end
					end
					else
						slot <= slot + 3'd1;
				end

				spr_next:
				begin
					if (last_spr)
						state <= halt;   // line rendered
					else
					begin
						sprite_idx <= sprite_idx + 1'b1;
						state      <= spr_check;
					end
				end

				default: state <= halt;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/sprite_row_addr.sv
`timescale 1ns/10ps
`default_nettype none

module sprite_row_addr
(
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       row_load,
	input  sprite_pkg::sprite_desc_t   desc,
	input  video_pkg::vline_t          line,
	output sprite_pkg::mem_addr_t      row_addr,
	output video_pkg::xpos_t           first_x
);
	import video_pkg::*;
	import sprite_pkg::*;

	vline_t      lofs;        // row within the sprite
	vline_t      span_m1;     // last row index
	logic [15:0] row_ofs;     // words before this row
	logic [9:0]  pix_cnt;     // pixels per row
	logic [9:0]  x_end;

	assign span_m1 = {desc.height_lines, 2'b00} - 9'd1;
	assign lofs    = desc.flip_y ? span_m1 - (line - desc.y_pos) : line - desc.y_pos;
	assign row_ofs = lofs * desc.width_words;

	// pixels in a row, by packing
	always_comb
	begin
		case (desc.cres)
			four_col:    pix_cnt = {desc.width_words, 3'b000};
			sixteen_col: pix_cnt = {1'b0, desc.width_words, 2'b00};
			default:     pix_cnt = {2'b00, desc.width_words, 1'b0};
		endcase
	end

	assign x_end = {1'b0, desc.x_pos} + pix_cnt - 10'd1;   // mirrored start

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			row_addr <= '0;
			first_x  <= '0;
		end
		else if (row_load)
		begin
			row_addr <= {desc.base_addr, 7'b0000000} + {5'b00000, row_ofs};
			first_x  <= desc.flip_x ? x_end[8:0] : desc.x_pos;
		end
	end

endmodule

`default_nettype wire

// File: design/pixel_colorizer.sv
`timescale 1ns/10ps
`default_nettype none

module pixel_colorizer
(
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  pal_we,
	input  logic [7:0]            pal_addr,
	input  logic [7:0]            pal_data,
	input  logic                  load_word,
	input  logic [15:0]           word,
	input  sprite_pkg::cres_e     cres,
	input  logic [5:0]            pal_sel,
	input  logic [2:0]            slot,
	input  logic                  pix_wr,
	output video_pkg::sl_word_t   wr_data,
	output logic                  wr_en
);
	import sprite_pkg::*;

	logic [7:0]  pal_mem [256];   // bit 7 opaque, bits 5:0 colour
	logic [15:0] word_q;          // fetched sprite word
	logic [15:0] word_sh;         // current pixel moved to the top
	logic [7:0]  pal_idx;
	logic [7:0]  src_byte;

	always_ff @(posedge clk)
	begin
		if (pal_we)
			pal_mem[pal_addr] <= pal_data;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			word_q <= '0;
		else if (load_word)
			word_q <= word;   // on spu_strobe
	end

	// msb first pixel order
	always_comb
	begin
		case (cres)
			four_col:    word_sh = word_q << {slot, 1'b0};
			sixteen_col: word_sh = word_q << {slot[1:0], 2'b00};
			default:     word_sh = word_q << {slot[0], 3'b000};
		endcase
	end

	// 16 colour mode keeps only the upper four bits of pal_sel
	assign pal_idx = (cres == four_col) ? {pal_sel, word_sh[15:14]}
		: {pal_sel[5:2], word_sh[15:12]};

	assign src_byte = (cres == true_col) ? word_sh[15:8] : pal_mem[pal_idx];

	assign wr_data.opaque = src_byte[7];
	assign wr_data.color  = src_byte[5:0];
	assign wr_en          = pix_wr & src_byte[7];   // see-through keeps old entry

endmodule

`default_nettype wire

// File: design/line_buffer_pair.sv
`timescale 1ns/10ps
`default_nettype none

`include "sprite_macros.svh"

module line_buffer_pair
(
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  back_sel,
	input  logic                  wr_en,
	input  video_pkg::xpos_t      wr_x,
	input  video_pkg::sl_word_t   wr_data,
	input  logic                  line_start,
	input  logic                  cbeg,
	output video_pkg::color_t     spixel,
	output logic                  spx_en
);
	import video_pkg::*;

	sl_word_t mem [2][`LINE_PIXELS];   // back_sel picks the half being drawn

	xpos_t    rd_ptr;
	logic     front_sel;
	logic     rd_ok;      // pointer still on the line
	logic     wr_ok;
	sl_word_t rd_word;

	assign front_sel = ~back_sel;
	assign rd_ok     = (rd_ptr < `LINE_PIXELS);
	assign wr_ok     = wr_en && (wr_x < `LINE_PIXELS);   // offscreen columns dropped
	assign rd_word   = rd_ok ? mem[front_sel][rd_ptr] : '0;

	// -----------------------------------------------------------------------
	// storage, sprite writes and clear behind read
	// -----------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (wr_ok)
			mem[back_sel][wr_x] <= wr_data;
		if (cbeg && !line_start && rd_ok)
			mem[front_sel][rd_ptr] <= '0;   // ready for the next render
	end

	// -----------------------------------------------------------------------
	// read out, one pixel per cbeg
	// -----------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			rd_ptr <= '0;
			spixel <= '0;
			spx_en <= 1'b0;
		end
		else if (line_start)
			rd_ptr <= '0;
		else if (cbeg)
		begin
			spixel <= rd_word.color;
			spx_en <= rd_word.opaque;
			if (rd_ok)
				rd_ptr <= rd_ptr + 9'd1;   // holds past the right edge
		end
	end

endmodule

`default_nettype wire

// File: design/sprite_engine.sv
`timescale 1ns/10ps
`default_nettype none

`include "sprite_macros.svh"

module sprite_engine
(
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     spu_en,
	input  logic                     line_start,
	input  logic                     pre_vline,
	input  logic                     cbeg,
	input  logic                     host_we,
	input  logic [10:0]              host_addr,   // bit 10 set selects palette
	input  logic [7:0]               host_wdata,
	output logic                     spu_req,
	output sprite_pkg::mem_addr_t    spu_addr,
	input  logic [15:0]              spu_data,
	input  logic                     spu_strobe,
	output video_pkg::color_t        spixel,
	output logic                     spx_en,
	output sprite_pkg::seq_state_e   state
);
	import video_pkg::*;
	import sprite_pkg::*;

	sprite_desc_t              desc;
	logic [`SPRITE_IDX_W-1:0]  sprite_idx;
	logic                      row_load;
	mem_addr_t                 row_addr;
	xpos_t                     first_x;
	vline_t                    line;
	logic                      load_word;
	logic [2:0]                slot;
	logic                      pix_wr;
	xpos_t                     wr_x;
	logic                      back_sel;
	sl_word_t                  sl_data;
	logic                      sl_we;

	// descriptor bytes, host_addr[6:3] sprite, [2:0] byte
	sprite_attr_file u_attr
	(
		.clk       (clk),
		.arst_n    (arst_n),
		.wr_en     (host_we & ~host_addr[10]),
		.wr_sprite (host_addr[3 +: `SPRITE_IDX_W]),
		.wr_byte   (host_addr[2:0]),
		.wr_data   (host_wdata),
		.rd_sprite (sprite_idx),
		.desc      (desc)
	);

	sprite_sequencer u_seq
	(
		.clk        (clk),
		.arst_n     (arst_n),
		.spu_en     (spu_en),
		.line_start (line_start),
		.pre_vline  (pre_vline),
		.desc       (desc),
		.spu_strobe (spu_strobe),
		.row_addr   (row_addr),
		.first_x    (first_x),
		.sprite_idx (sprite_idx),
		.row_load   (row_load),
		.line       (line),
		.spu_req    (spu_req),
		.spu_addr   (spu_addr),
		.load_word  (load_word),
		.slot       (slot),
		.pix_wr     (pix_wr),
		.wr_x       (wr_x),
		.state      (state),
		.back_sel   (back_sel)
	);

	sprite_row_addr u_row
	(
		.clk      (clk),
		.arst_n   (arst_n),
		.row_load (row_load),
		.desc     (desc),
		.line     (line),
		.row_addr (row_addr),
		.first_x  (first_x)
	);

	pixel_colorizer u_color
	(
		.clk       (clk),
		.arst_n    (arst_n),
		.pal_we    (host_we & host_addr[10]),
		.pal_addr  (host_addr[7:0]),
		.pal_data  (host_wdata),
		.load_word (load_word),
		.word      (spu_data),
		.cres      (desc.cres),
		.pal_sel   (desc.pal_sel),
		.slot      (slot),
		.pix_wr    (pix_wr),
		.wr_data   (sl_data),
		.wr_en     (sl_we)
	);

	line_buffer_pair u_lbuf
	(
		.clk        (clk),
		.arst_n     (arst_n),
		.back_sel   (back_sel),
		.wr_en      (sl_we),
		.wr_x       (wr_x),
		.wr_data    (sl_data),
		.line_start (line_start),
		.cbeg       (cbeg),
		.spixel     (spixel),
		.spx_en     (spx_en)
	);

endmodule

`default_nettype wire

// File: verification/tb_sprite_memory.sv
`timescale 1ns/10ps
`default_nettype none

module tb_sprite_memory
(
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    req,
	input  sprite_pkg::mem_addr_t   addr,
	output logic [15:0]             data,
	output logic                    strobe
);
	import sprite_pkg::*;

	int unsigned delay_cnt;   // cycles left before the strobe

	// word contents, spread over the whole 21-bit address
	function automatic logic [15:0] mem_word(input mem_addr_t a);
		logic [31:0] t;
		t = {11'd0, a} * 32'h9E3779B1;
		return t[31:16] ^ t[15:0];
	endfunction

	always @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			strobe    <= 1'b0;
			data      <= '0;
			delay_cnt <= $urandom_range(0, 5);
		end
		else if (strobe)
		begin
			strobe    <= 1'b0;                  // req drops on this edge
			delay_cnt <= $urandom_range(0, 5);  // next word latency
		end
		else if (req)
		begin
			if (delay_cnt == 0)
			begin
				strobe <= 1'b1;
				data   <= mem_word(addr);
			end
			else
				delay_cnt <= delay_cnt - 1;
		end
	end

endmodule

`default_nettype wire

// File: verification/tb_sprite_engine.sv
`timescale 1ns/10ps
`default_nettype none

`include "sprite_macros.svh"

module tb_sprite_engine;
	import video_pkg::*;
	import sprite_pkg::*;

	logic clk;
	logic arst_n;
	logic spu_en;
	logic line_start;
	logic pre_vline;
	logic cbeg;
	logic host_we;
	logic [10:0] host_addr;
	logic [7:0] host_wdata;
	logic spu_req;
	mem_addr_t spu_addr;
	logic [15:0] spu_data;
	logic spu_strobe;
	color_t spixel;
	logic spx_en;
	seq_state_e state;

	sprite_desc_t descs [`SPRITE_COUNT];   // host copy of descriptors
	logic [7:0]   pal [256];
	logic         exp_en [`LINE_PIXELS];    // line now being read out
	color_t       exp_col [`LINE_PIXELS];
	logic         cur_en [`LINE_PIXELS];    // line now being rendered
	color_t       cur_col [`LINE_PIXELS];
	int           rd_cnt;
	int           chk_idx;
	logic         check_on;
	logic         render_on;
	vline_t       tb_line;

	sprite_engine UUT
	(
		.clk(clk), .arst_n(arst_n), .spu_en(spu_en), .line_start(line_start),
		.pre_vline(pre_vline), .cbeg(cbeg), .host_we(host_we), .host_addr(host_addr),
		.host_wdata(host_wdata), .spu_req(spu_req), .spu_addr(spu_addr),
		.spu_data(spu_data), .spu_strobe(spu_strobe), .spixel(spixel),
		.spx_en(spx_en), .state(state)
	);

	tb_sprite_memory u_mem
	(
		.clk(clk), .arst_n(arst_n), .req(spu_req), .addr(spu_addr),
		.data(spu_data), .strobe(spu_strobe)
	);

	always #10 clk = ~clk;

	// read pointer copy, index of the pixel checked one cycle later
	always @(posedge clk)
	begin
		if (line_start)
			rd_cnt <= 0;
		else if (cbeg)
			rd_cnt <= rd_cnt + 1;
		chk_idx <= rd_cnt;
	end

	// ------------------------------------------------------------------------
	// read-out checks
	// ------------------------------------------------------------------------
	assert property (@(posedge clk) disable iff (!arst_n || !check_on)
		cbeg |=> (spx_en === exp_en[chk_idx]))
	else
	begin
		$display("MISMATCH time=%0t spx_en column=%0d expected=%0b actual=%0b",
			$time, $sampled(chk_idx), exp_en[$sampled(chk_idx)], $sampled(spx_en));
		$display("*** TEST FAILED ***");
		$fatal(1, "spx_en check failed");
	end

	assert property (@(posedge clk) disable iff (!arst_n || !check_on)
		cbeg |=> (spixel === exp_col[chk_idx]))
	else
	begin
		$display("MISMATCH time=%0t spixel column=%0d expected=%0h actual=%0h",
			$time, $sampled(chk_idx), exp_col[$sampled(chk_idx)], $sampled(spixel));
		$display("*** TEST FAILED ***");
		$fatal(1, "spixel check failed");
	end

	// same word contents as the memory model
	function automatic logic [15:0] word_at(input mem_addr_t a);
		logic [31:0] t;
		t = {11'd0, a} * 32'h9E3779B1;
		return t[31:16] ^ t[15:0];
	endfunction

	function automatic logic [7:0] pal_byte(input int i);
		logic [5:0] c;
		c = (i * 29 + 3) % 64;
		return {((i * 37 + 11) % 7) != 0, 1'b0, c};   // about one in seven see-through
	endfunction

	function automatic sprite_desc_t make_desc(input int x, input int y, input int ww,
		input int hh, input cres_e cr, input int ps, input bit fx, input bit fy,
		input int base);
		sprite_desc_t d;
		d              = '0;
		d.x_pos        = x;
		d.y_pos        = y;
		d.width_words  = ww;
		d.height_lines = hh;
		d.cres         = cr;
		d.pal_sel      = ps;
		d.flip_x       = fx;
		d.flip_y       = fy;
		d.base_addr    = base;
		return d;
	endfunction

	// ------------------------------------------------------------------------
	// reference line, sprites in index order, later ones on top
	// ------------------------------------------------------------------------
	task automatic build_model(input vline_t ln);
		sprite_desc_t d;
		int n;
		int bits;
		int lofs;
		int yend;
		mem_addr_t row;
		logic [15:0] wd;
		logic [7:0] pix;
		logic [7:0] b;
		logic [8:0] x;
		for (int i = 0; i < `LINE_PIXELS; i++)
		begin
			cur_en[i]  = 1'b0;
			cur_col[i] = '0;
		end
		for (int s = 0; s < `SPRITE_COUNT; s++)
		begin
			d    = descs[s];
			yend = d.y_pos + 4 * d.height_lines;
			if (!render_on || d.cres == off || ln < d.y_pos || ln >= yend)
				continue;
			n    = (d.cres == four_col) ? 8 : (d.cres == sixteen_col) ? 4 : 2;
			bits = 16 / n;
			lofs = ln - d.y_pos;
			if (d.flip_y)
				lofs = 4 * d.height_lines - 1 - lofs;   // bottom row first
			row = {d.base_addr, 7'd0} + lofs * d.width_words;
			for (int p = 0; p < n * d.width_words; p++)
			begin
				wd  = word_at(row + p / n);
				pix = (wd >> (16 - bits * (p % n + 1))) & ((1 << bits) - 1);
				case (d.cres)
					four_col:    b = pal[{d.pal_sel, pix[1:0]}];
					sixteen_col: b = pal[{d.pal_sel[5:2], pix[3:0]}];
					default:     b = pix;
				endcase
				x = d.flip_x ? d.x_pos + n * d.width_words - 1 - p : d.x_pos + p;
				if (b[7] && x < `LINE_PIXELS)
				begin
					cur_en[x]  = 1'b1;
					cur_col[x] = b[5:0];
				end
			end
		end
	endtask

	task automatic host_write(input logic [10:0] a, input logic [7:0] v);
		@(posedge clk);
		host_we    <= 1'b1;
		host_addr  <= a;
		host_wdata <= v;
		@(posedge clk);
		host_we    <= 1'b0;
	endtask

	task automatic write_desc(input int s, input sprite_desc_t d);
		logic [3:0] si;
		si       = s;
		descs[s] = d;
		for (int b = 0; b < 8; b++)
			host_write({4'b0000, si, b[2:0]}, d[8 * b +: 8]);
	endtask

	// one video line: swap, full read-out, then wait for the render to end
	task automatic step_line(input bit pre);
		int cnt;
		for (int i = 0; i < `LINE_PIXELS; i++)
		begin
			exp_en[i]  = cur_en[i];
			exp_col[i] = cur_col[i];
		end
		if (pre)
			tb_line = '0;
		else if (tb_line != `VIS_LINES)
			tb_line = tb_line + 9'd1;
		@(posedge clk);
		line_start <= 1'b1;
		pre_vline  <= pre;
		@(posedge clk);
		line_start <= 1'b0;
		pre_vline  <= 1'b0;
		build_model(tb_line);
		for (int i = 0; i < `LINE_PIXELS; i++)
		begin
			@(posedge clk);
			cbeg <= 1'b1;
		end
		@(posedge clk);
		cbeg <= 1'b0;
		cnt = 0;
		while (state !== halt)
		begin
			if (cnt >= 3000)
			begin
				$display("sprite line not finished before line start, line %0d", tb_line);
				$display("*** TEST FAILED ***");
				$fatal(1, "render timeout");
			end
			cnt++;
			@(posedge clk);
		end
		repeat (3) @(posedge clk);
	endtask

	// reset values of the request, the pixel enable and the FSM
	task automatic check_idle(input string when);
		assert (spu_req === 1'b0)
		else
		begin
			$display("MISMATCH time=%0t spu_req %s expected=0 actual=%b",
				$time, when, spu_req);
			$display("*** TEST FAILED ***");
			$fatal(1, "reset check failed");
		end
		assert (spx_en === 1'b0)
		else
		begin
			$display("MISMATCH time=%0t spx_en %s expected=0 actual=%b",
				$time, when, spx_en);
			$display("*** TEST FAILED ***");
			$fatal(1, "reset check failed");
		end
		assert (state === halt)
		else
		begin
			$display("MISMATCH time=%0t state %s expected=halt actual=%s",
				$time, when, state.name());
			$display("*** TEST FAILED ***");
			$fatal(1, "reset check failed");
		end
	endtask

	initial
	begin
		int x0;
		int cnt;
		void'($urandom(98336));
		clk        = 1'b0;
		arst_n     = 1'b0;
		spu_en     = 1'b0;
		line_start = 1'b0;
		pre_vline  = 1'b0;
		cbeg       = 1'b0;
		host_we    = 1'b0;
		host_addr  = '0;
		host_wdata = '0;
		check_on   = 1'b0;
		render_on  = 1'b0;
		tb_line    = '0;
		rd_cnt     = 0;
		chk_idx    = 0;
		for (int s = 0; s < `SPRITE_COUNT; s++)
			descs[s] = '0;
		build_model(tb_line);
		repeat (8) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);
		check_idle("after reset");

		// two blank lines wipe both halves through clear-behind-read
		step_line(1'b0);
		step_line(1'b0);

		for (int i = 0; i < 256; i++)
			host_write({3'b100, i[7:0]}, pal_byte(i));
		for (int i = 0; i < 256; i++)
			pal[i] = pal_byte(i);

		// --------------------------------------------------------------------
		// sprite set: one per mode, a flipped pair overlapping, one past the edge
		// --------------------------------------------------------------------
		write_desc(0, make_desc($urandom_range(0, 300), 1, 2, 1, four_col, 5, 0, 0, 14'h0011));
		write_desc(1, make_desc($urandom_range(0, 300), 3, 3, 1, sixteen_col, 22, 0, 0,
			14'h0123));
		write_desc(2, make_desc($urandom_range(0, 300), 5, 4, 1, true_col, 0, 0, 0, 14'h2a05));
		x0 = $urandom_range(0, 300);
		write_desc(3, make_desc(x0, 8, 2, 2, four_col, 9, 1, 1, 14'h0777));
		write_desc(4, make_desc(x0 + 4, 9, 2, 1, sixteen_col, 40, 0, 0, 14'h1f00));
		write_desc(5, make_desc(350, 0, 8, 1, true_col, 0, 0, 0, 14'h3ffe));

		@(posedge clk);
		spu_en   <= 1'b1;
		render_on = 1'b1;
		check_on <= 1'b1;
		step_line(1'b1);   // frame start, line 0
		repeat (17) step_line(1'b0);

		// reset in the middle of a render, frame restart so sprite 5 is fetched
		check_on <= 1'b0;
		@(posedge clk);
		line_start <= 1'b1;
		pre_vline  <= 1'b1;
		@(posedge clk);
		line_start <= 1'b0;
		pre_vline  <= 1'b0;
		cnt = 0;
		while (spu_req !== 1'b1)
		begin
			if (cnt >= 200)
			begin
				$display("no memory request seen during the render before reset");
				$display("*** TEST FAILED ***");
				$fatal(1, "request timeout");
			end
			cnt++;
			@(posedge clk);
		end
		arst_n <= 1'b0;   // request still out
		repeat (8) @(posedge clk);
		check_idle("during reset");
		arst_n <= 1'b1;
		repeat (2) @(posedge clk);
		check_idle("after second reset");

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+include
design/video_pkg.sv
design/sprite_pkg.sv
design/sprite_attr_file.sv
design/sprite_sequencer.sv
design/sprite_row_addr.sv
design/pixel_colorizer.sv
design/line_buffer_pair.sv
design/sprite_engine.sv
verification/tb_sprite_memory.sv
verification/tb_sprite_engine.sv

// File: Bender.yml
package:
  name: sprite_engine

sources:
  - include_dirs:
      - include
    files:
      - design/video_pkg.sv
      - design/sprite_pkg.sv
      - design/sprite_attr_file.sv
      - design/sprite_sequencer.sv
      - design/sprite_row_addr.sv
      - design/pixel_colorizer.sv
      - design/line_buffer_pair.sv
      - design/sprite_engine.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/tb_sprite_memory.sv
      - verification/tb_sprite_engine.sv
